//--- hw/conv_pkg.sv
package conv_pkg;

    typedef logic [7:0] pixel_t;            // unsigned grayscale sample
    typedef logic signed [7:0] weight_t;    // signed kernel coefficient
    typedef logic signed [31:0] acc_t;      // mac sum and output word
    typedef logic [3:0] tap_t;              // window position 0..8, row-major

    // controller sequence for one image
    typedef enum logic [2:0] {
        idle,
        load,           // first three image rows into the line buffer
        mac_clear,
        mac_feed,       // nine taps into the mac
        mac_drain,      // wait out the mac pipeline
        write,
        next_row_load,  // refill the bottom row before the next output row
        finish
    } conv_state_t;

endpackage

//--- hw/kernel_regs.sv
module kernel_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              kw_we,
    input  conv_pkg::tap_t    kw_addr,
    input  conv_pkg::weight_t kw_data,
    input  conv_pkg::tap_t    tap,
    output conv_pkg::weight_t weight
);

    conv_pkg::weight_t coef [9];            // row-major 3x3 kernel

    // out of reset the kernel detects horizontal edges
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 9; i++) begin
                if (i < 3) begin
                    coef[i] <= -8'sd1;      // top row
                end else if (i < 6) begin
                    coef[i] <= 8'sd0;
                end else begin
                    coef[i] <= 8'sd1;       // bottom row
                end
            end
        end else if (kw_we && kw_addr < 4'd9) begin
            coef[kw_addr] <= kw_data;
        end
    end

    assign weight = (tap < 4'd9) ? coef[tap] : '0;  // taps past 8 read as zero

endmodule

//--- hw/line_buffer.sv
interface lb_if #(
    parameter int img_width = 8
);
    localparam int col_w = $clog2(img_width);

    logic              fill;                // write fill_data at the bottom row pointer
    conv_pkg::pixel_t  fill_data;
    logic              advance;             // shift rows up by one
    logic [1:0]        tap_row;
    logic [col_w-1:0]  tap_col;
    conv_pkg::pixel_t  tap_pixel;

    modport ctrl (
        output fill,
        output fill_data,
        output advance,
        output tap_row,
        output tap_col,
        input  tap_pixel
    );

    modport buffer (
        input  fill,
        input  fill_data,
        input  advance,
        input  tap_row,
        input  tap_col,
        output tap_pixel
    );
endinterface

module line_buffer #(
    parameter int img_width = 8
) (
    input logic  clk,
    input logic  rst,
    lb_if.buffer lb
);

    localparam int col_w = $clog2(img_width);

    conv_pkg::pixel_t rows [3][img_width];  // row 0 is the oldest line
    logic [col_w-1:0] wr_col;               // next bottom-row column to fill

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_col <= '0;
        end else if (lb.advance) begin
            wr_col <= '0;                   // new line starts at column 0
        end else if (lb.fill) begin
            if (wr_col == col_w'(img_width - 1)) begin
                wr_col <= '0;
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

    // pixel storage
    always_ff @(posedge clk) begin
        if (lb.advance) begin
            rows[0] <= rows[1];
            rows[1] <= rows[2];
        end else if (lb.fill) begin
            rows[2][wr_col] <= lb.fill_data;
        end
    end

    assign lb.tap_pixel = (lb.tap_row == 2'd3) ? '0 : rows[lb.tap_row][lb.tap_col];

endmodule

//--- hw/mac_unit.sv
interface mac_if;
    logic              clear;               // zero both pipeline stages
    logic              en;                  // a and b hold a valid tap
    conv_pkg::pixel_t  a;
    conv_pkg::weight_t b;
    conv_pkg::acc_t    acc;

    modport ctrl (output clear, output en, output a, output b, input acc);
    modport mac  (input clear, input en, input a, input b, output acc);
endinterface

module mac_unit (
    input logic clk,
    input logic rst,
    mac_if.mac  m
);

    logic signed [16:0] prod;               // 9-bit signed pixel times 8-bit weight
    logic               prod_vld;

    // stage 2 accumulates whatever stage 1 produced
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prod_vld <= 1'b0;
            m.acc    <= '0;
        end else if (m.clear) begin
            prod_vld <= 1'b0;
            m.acc    <= '0;
        end else begin
            prod_vld <= m.en;
            if (prod_vld) begin
                m.acc <= m.acc + conv_pkg::acc_t'(prod);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m.clear) begin
            prod <= '0;
        end else if (m.en) begin
            prod <= $signed({1'b0, m.a}) * m.b;  // pixel is zero-extended
        end
    end

endmodule

//--- hw/conv_ctrl.sv
module conv_ctrl #(
    parameter int  img_width  = 8,
    parameter int  img_height = 8,
    localparam int pix_aw     = $clog2(img_width * img_height),
    localparam int out_aw     = $clog2((img_width - 2) * (img_height - 2))
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              done,
    output logic [pix_aw-1:0] pix_addr,
    input  conv_pkg::pixel_t  pix_data,
    output conv_pkg::tap_t    tap,
    input  conv_pkg::weight_t weight,
    lb_if.ctrl                lb,
    mac_if.ctrl               m,
    output logic              out_we,
    output logic [out_aw-1:0] out_addr,
    output conv_pkg::acc_t    out_data
);

    localparam int cnt_w = $clog2(img_width + 1);
    localparam int col_w = $clog2(img_width);
    localparam int row_w = $clog2(img_height);

    conv_pkg::conv_state_t state;

    logic [pix_aw-1:0] rd_addr;             // next pixel to request
    logic [cnt_w-1:0]  rd_cnt;              // reads issued for the current row
    logic              rd_vld;              // pix_data answers last cycle's address
    logic [1:0]        rows_done;           // rows completed in the initial load
    logic              adv;
    logic [col_w-1:0]  out_col;             // left column of the window
    logic [row_w-1:0]  out_row;             // top row of the window
    logic [out_aw-1:0] out_idx;             // row-major output address
    conv_pkg::tap_t    tap_cnt;
    logic              drain_cnt;
    logic [1:0]        win_col;             // column offset inside the window

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= conv_pkg::idle;
            rd_addr   <= '0;
            rd_cnt    <= '0;
            rd_vld    <= 1'b0;
            rows_done <= '0;
            adv       <= 1'b0;
            out_col   <= '0;
            out_row   <= '0;
            out_idx   <= '0;
            tap_cnt   <= '0;
            drain_cnt <= 1'b0;
        end else begin
            adv <= 1'b0;
            case (state)
                conv_pkg::idle: begin
                    if (start) begin
                        rd_addr   <= '0;
                        rd_cnt    <= '0;
                        rd_vld    <= 1'b0;
                        rows_done <= '0;
                        out_col   <= '0;
                        out_row   <= '0;
                        out_idx   <= '0;
                        state     <= conv_pkg::load;
                    end
                end
                conv_pkg::load, conv_pkg::next_row_load: begin
                    if (rd_cnt != cnt_w'(img_width)) begin
                        rd_addr <= rd_addr + 1'b1;
                        rd_cnt  <= rd_cnt + 1'b1;
                        rd_vld  <= 1'b1;
                    end else if (rd_vld) begin
                        rd_vld <= 1'b0;     // last fill of the row happens now
                    end else if (rows_done != 2'd2) begin
                        rows_done <= rows_done + 1'b1;
                        rd_cnt    <= '0;
                        adv       <= 1'b1;  // make room before the next row arrives
                    end else begin
                        state <= conv_pkg::mac_clear;
                    end
                end
                conv_pkg::mac_clear: begin
                    tap_cnt <= '0;
                    state   <= conv_pkg::mac_feed;
                end
                conv_pkg::mac_feed: begin
                    if (tap_cnt == 4'd8) begin
                        drain_cnt <= 1'b0;
                        state     <= conv_pkg::mac_drain;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                conv_pkg::mac_drain: begin
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        state <= conv_pkg::write;
                    end
                end
                conv_pkg::write: begin
                    out_idx <= out_idx + 1'b1;
                    if (out_col != col_w'(img_width - 3)) begin
                        out_col <= out_col + 1'b1;
                        state   <= conv_pkg::mac_clear;
                    end else if (out_row != row_w'(img_height - 3)) begin
                        out_col <= '0;
                        out_row <= out_row + 1'b1;
                        rd_cnt  <= '0;
                        adv     <= 1'b1;    // drop the oldest line
                        state   <= conv_pkg::next_row_load;
                    end else begin
                        state <= conv_pkg::finish;
                    end
                end
                conv_pkg::finish: begin
                    state <= conv_pkg::idle;
                end
                default: begin
                    state <= conv_pkg::idle;
                end
            endcase
        end
    end

    assign pix_addr     = rd_addr;
    assign lb.fill      = rd_vld;
    assign lb.fill_data = pix_data;
    assign lb.advance   = adv;

    // tap counter to window position
    assign tap        = tap_cnt;
    assign lb.tap_row = 2'(tap_cnt / 4'd3);
    assign win_col    = 2'(tap_cnt % 4'd3);
    assign lb.tap_col = out_col + col_w'(win_col);

    assign m.clear = (state == conv_pkg::mac_clear);
    assign m.en    = (state == conv_pkg::mac_feed);
    assign m.a     = lb.tap_pixel;
    assign m.b     = weight;

    assign out_we   = (state == conv_pkg::write);
    assign out_addr = out_idx;
    assign out_data = (m.acc < 0) ? '0 : m.acc;    // relu
    assign done     = (state == conv_pkg::finish);

endmodule

//--- hw/conv3x3_top.sv
module conv3x3_top #(
    parameter int  img_width  = 8,
    parameter int  img_height = 8,
    localparam int pix_aw     = $clog2(img_width * img_height),
    localparam int out_aw     = $clog2((img_width - 2) * (img_height - 2))
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              done,
    output logic [pix_aw-1:0] pix_addr,
    input  conv_pkg::pixel_t  pix_data,
    input  logic              kw_we,
    input  conv_pkg::tap_t    kw_addr,
    input  conv_pkg::weight_t kw_data,
    output logic              out_we,
    output logic [out_aw-1:0] out_addr,
    output conv_pkg::acc_t    out_data
);

    conv_pkg::tap_t    tap;                 // weight select from the controller
    conv_pkg::weight_t weight;

    lb_if #(.img_width(img_width)) lb_bus ();
    mac_if mac_bus ();

    kernel_regs kernel_regs_i (
        .clk     (clk),
        .rst     (rst),
        .kw_we   (kw_we),
        .kw_addr (kw_addr),
        .kw_data (kw_data),
        .tap     (tap),
        .weight  (weight)
    );

    line_buffer #(
        .img_width (img_width)
    ) line_buffer_i (
        .clk (clk),
        .rst (rst),
        .lb  (lb_bus)
    );

    mac_unit mac_unit_i (
        .clk (clk),
        .rst (rst),
        .m   (mac_bus)
    );

    conv_ctrl #(
        .img_width  (img_width),
        .img_height (img_height)
    ) conv_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .done     (done),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .tap      (tap),
        .weight   (weight),
        .lb       (lb_bus),
        .m        (mac_bus),
        .out_we   (out_we),
        .out_addr (out_addr),
        .out_data (out_data)
    );

endmodule

//--- verif/conv3x3_tb.sv
module conv3x3_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int img_w         = 8;
    localparam int img_h         = 8;
    localparam int out_w         = img_w - 2;
    localparam int n_out         = (img_w - 2) * (img_h - 2);
    localparam int done_timeout  = 2000;     // cycles from start to done

    logic              clk = 1'b0;
    logic              rst;
    logic              start;
    logic              done;
    logic [5:0]        pix_addr;
    conv_pkg::pixel_t  pix_data = '0;
    logic              kw_we;
    conv_pkg::tap_t    kw_addr;
    conv_pkg::weight_t kw_data;
    logic              out_we;
    logic [5:0]        out_addr;
    conv_pkg::acc_t    out_data;

    conv_pkg::pixel_t  pix_mem [img_w * img_h];  // row-major image
    conv_pkg::weight_t kern_model [9];           // what the kernel registers should hold
    conv_pkg::acc_t    out_mem [64];
    int                write_total = 0;          // all out_we strobes seen so far
    int                run_base = 0;             // write_total when the current run began
    int                seed = 32'h80d7_6d19;

    conv3x3_top conv3x3_top_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .done     (done),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .kw_we    (kw_we),
        .kw_addr  (kw_addr),
        .kw_data  (kw_data),
        .out_we   (out_we),
        .out_addr (out_addr),
        .out_data (out_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        pix_data <= pix_mem[pix_addr];           // one cycle read latency
    end

    // expected relu output at window position (r, c)
    function automatic conv_pkg::acc_t conv_ref(input int r, input int c);
        int sum;
        sum = 0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                sum += int'(pix_mem[(r + i) * img_w + c + j]) * int'(kern_model[i * 3 + j]);
            end
        end
        if (sum < 0) begin
            sum = 0;
        end
        return conv_pkg::acc_t'(sum);
    endfunction

    task automatic check_acc(input conv_pkg::acc_t exp, input conv_pkg::acc_t act,
                             input string what);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s expected %0d, got %0d", $time, what, exp, act);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s expected %0d, got %0d", $time, what, exp, act);
            $display("Testbench failed");
            $fatal(1, "count mismatch");
        end
    endtask

    // every write is checked against the model as it arrives
    always @(negedge clk) begin
        if (!rst && out_we) begin
            check_count(write_total - run_base, int'(out_addr), "output address");
            check_acc(conv_ref(int'(out_addr) / out_w, int'(out_addr) % out_w), out_data,
                      "output value");
            out_mem[out_addr] = out_data;
            write_total = write_total + 1;
        end
    end

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_count(0, int'(done), "done while idle");
            check_count(0, int'(out_we), "out_we while idle");
        end
    endtask

    task automatic fill_random_image();
        for (int i = 0; i < img_w * img_h; i++) begin
            pix_mem[i] = conv_pkg::pixel_t'($random(seed));
        end
    endtask

    task automatic fill_constant_image(input conv_pkg::pixel_t value);
        for (int i = 0; i < img_w * img_h; i++) begin
            pix_mem[i] = value;
        end
    endtask

    // copies kern_model into the kernel registers
    task automatic push_kernel();
        for (int i = 0; i < 9; i++) begin
            @(posedge clk);
            kw_we   <= 1'b1;
            kw_addr <= conv_pkg::tap_t'(i);
            kw_data <= kern_model[i];
        end
        @(posedge clk);
        kw_we <= 1'b0;
    endtask

    // start strobe, optional second strobe at busy_at, then wait for done
    task automatic run_conv(input int busy_at);
        int cyc;
        logic seen;
        run_base = write_total;
        cyc = 0;
        seen = 1'b0;
        while (!seen && cyc < done_timeout) begin
            @(posedge clk);
            start <= (cyc == 0) || (busy_at > 0 && cyc == busy_at);
            @(negedge clk);
            seen = done;
            cyc++;
        end
        if (!seen) begin
            $display("Timeout: done did not arrive within %0d cycles", done_timeout);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
        check_count(n_out, write_total - run_base, "write count");
    endtask

    task automatic expect_all(input conv_pkg::acc_t value);
        for (int i = 0; i < n_out; i++) begin
            check_acc(value, out_mem[i], "constant image output");
        end
    endtask

    initial begin
        rst     <= 1'b1;
        start   <= 1'b0;
        kw_we   <= 1'b0;
        kw_addr <= '0;
        kw_data <= '0;
        for (int i = 0; i < 9; i++) begin
            kern_model[i] = (i < 3) ? -8'sd1 : ((i < 6) ? 8'sd0 : 8'sd1);  // edge kernel
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        expect_idle(20);

        fill_random_image();
        run_conv(0);

        for (int i = 0; i < 9; i++) begin
            kern_model[i] = conv_pkg::weight_t'($random(seed));
        end
        push_kernel();
        fill_random_image();
        run_conv(0);

        // saturated image gives the relu floor and the largest positive sum
        fill_constant_image(8'd255);
        for (int i = 0; i < 9; i++) begin
            kern_model[i] = -8'sd1;
        end
        push_kernel();
        run_conv(0);
        expect_all(0);
        for (int i = 0; i < 9; i++) begin
            kern_model[i] = 8'sd1;
        end
        push_kernel();
        run_conv(0);
        expect_all(2295);

        // back to back runs where the second gets a stray start mid-run
        fill_random_image();
        run_conv(0);
        fill_random_image();
        run_conv(60);
        expect_idle(40);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- conv3x3_top.f
hw/conv_pkg.sv
hw/kernel_regs.sv
hw/line_buffer.sv
hw/mac_unit.sv
hw/conv_ctrl.sv
hw/conv3x3_top.sv
verif/conv3x3_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -f conv3x3_top.f --top-module conv3x3_tb -o conv3x3_sim \
    && ./obj_dir/conv3x3_sim \
    || exit 1
